// File: build.f
+incdir+design
design/sat_pkg.sv
design/lit_decode.sv
design/clause_eval.sv
design/clause_cell.sv
design/clause_array.sv
sim/tb_clause_array.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the clause array testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_clause_array -f build.f -o tb_clause_array

out=$(./obj_dir/tb_clause_array)
printf '%s\n' "$out"

# the run passes only if the testbench printed the pass line
echo "$out" | grep -qx "Simulation finished: PASS"

// File: sim/tb_clause_array.sv
`timescale 1ns/100ps
`include "sat_cfg.svh"

module tb_clause_array import sat_pkg::*;;

    typedef enum logic [1:0] {OP_WRITE, OP_EVAL, OP_IMPL, OP_BKT} op_t;

    // want holds {known, all_sat, conflict} and known is clear for random rows
    typedef struct packed {
        op_t                                op;
        logic [$clog2(`SAT_NUM_CLAUSES)-1:0] idx;
        clause_vec_t                        clause;
        logic [`SAT_LEN_W-1:0]              len;
        var_vec_t                           vars;
        logic [2:0]                         want;
    } row_t;

    localparam logic [2:0] W_SAT  = 3'b110;
    localparam logic [2:0] W_OPEN = 3'b100;
    localparam logic [2:0] W_CONF = 3'b101;

    logic                                         clk;
    logic                                         rst;
    logic [`SAT_NUM_CLAUSES-1:0]                  wr_i;
    clause_vec_t                                  clause_i;
    logic [`SAT_LEN_W-1:0]                        clause_len_i;
    logic                                         rd_en_i;
    logic [$clog2(`SAT_NUM_CLAUSES)-1:0]          rd_i;
    clause_vec_t                                  clause_o;
    logic [`SAT_NUM_CLAUSES-1:0][`SAT_LEN_W-1:0]  clause_len_o;
    var_vec_t                                     var_value_i;
    var_vec_t                                     var_value_o;
    logic                                         apply_impl_i;
    logic                                         apply_bkt_i;
    logic                                         all_sat_o;
    logic                                         conflict_o;

    row_t   rows[$];
    string  names[$];
    integer seed = 34004;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit = 0;

    // reference state that mirrors what the array should hold
    clause_vec_t            mclause  [`SAT_NUM_CLAUSES] = '{default: clause_vec_t'(0)};
    logic [`SAT_LEN_W-1:0]  mlen     [`SAT_NUM_CLAUSES] = '{default: '0};
    logic                   reason   [`SAT_NUM_CLAUSES] = '{default: 1'b0};
    logic                   need_clr [`SAT_NUM_CLAUSES] = '{default: 1'b0};

    clause_array dut0 (
        .clk          (clk),
        .rst          (rst),
        .wr_i         (wr_i),
        .clause_i     (clause_i),
        .clause_len_i (clause_len_i),
        .rd_en_i      (rd_en_i),
        .rd_i         (rd_i),
        .clause_o     (clause_o),
        .clause_len_o (clause_len_o),
        .var_value_i  (var_value_i),
        .var_value_o  (var_value_o),
        .apply_impl_i (apply_impl_i),
        .apply_bkt_i  (apply_bkt_i),
        .all_sat_o    (all_sat_o),
        .conflict_o   (conflict_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------

    function automatic clause_vec_t make_clause(logic [7:0] pos, logic [7:0] neg);
        clause_vec_t c;
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            c[i] = pos[i] ? LIT_POS : (neg[i] ? LIT_NEG : LIT_NONE);
        end
        return c;
    endfunction

    function automatic var_vec_t make_vars(logic [7:0] asg, logic [7:0] val);
        var_vec_t v;
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            v[i].implied  = 1'b0;   // table rows carry decisions only
            v[i].assigned = asg[i];
            v[i].value    = val[i];
        end
        return v;
    endfunction

    task automatic add_row(string name, op_t op, logic [1:0] idx, clause_vec_t c,
                           logic [`SAT_LEN_W-1:0] len, var_vec_t v, logic [2:0] want);
        row_t row;
        row.op     = op;
        row.idx    = idx;
        row.clause = c;
        row.len    = len;
        row.vars   = v;
        row.want   = want;
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic add_random_rows(int n);
        integer      r1;
        integer      r2;
        clause_vec_t c;
        var_vec_t    v;
        for (int k = 0; k < n; k++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            for (int i = 0; i < `SAT_NUM_VARS; i++) begin
                c[i] = (r1[2*i +: 2] == 2'b11) ? LIT_NONE : lit_code_t'(r1[2*i +: 2]);
            end
            v = make_vars(r2[7:0], r2[15:8]);
            for (int i = 0; i < `SAT_NUM_VARS; i++) begin
                v[i].implied = r1[16 + i];   // assigned inputs keep this bit on the way out
            end
            add_row($sformatf("rand_%0d", k), op_t'(r2[17:16]), r2[19:18], c, r2[23:20],
                    v, 3'b000);
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------

    function automatic clause_status_t clause_status_of(clause_vec_t c, var_vec_t v);
        clause_status_t st;
        int n_lit;
        int n_true;
        int n_free;
        n_lit  = 0;
        n_true = 0;
        n_free = 0;
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            if (c[i] == LIT_POS || c[i] == LIT_NEG) begin
                n_lit++;
                if (!v[i].assigned) n_free++;
                else if (v[i].value == (c[i] == LIT_POS)) n_true++;
            end
        end
        st.sat      = (n_true > 0);
        st.empty    = (n_lit == 0);
        st.conflict = !st.sat && !st.empty && (n_free == 0);
        st.unit     = !st.sat && (n_free == 1);
        return st;
    endfunction

    function automatic var_vec_t implied_by(clause_vec_t c, var_vec_t v);
        var_vec_t       imp;
        clause_status_t st;
        imp = '0;
        st  = clause_status_of(c, v);
        if (st.unit) begin
            for (int i = 0; i < `SAT_NUM_VARS; i++) begin
                if (c[i] != LIT_NONE && !v[i].assigned) begin
                    imp[i].implied  = 1'b1;
                    imp[i].assigned = 1'b1;
                    imp[i].value    = (c[i] == LIT_POS);
                end
            end
        end
        return imp;
    endfunction

    // reason and need_clear take the values of the edge that ends this row
    task automatic step_model(row_t row);
        clause_status_t st;
        logic           nr;
        logic           nn;
        for (int c = 0; c < `SAT_NUM_CLAUSES; c++) begin
            st = clause_status_of(mclause[c], row.vars);
            nr = reason[c];
            if (row.op == OP_IMPL && st.unit) nr = 1'b1;
            else if (row.op == OP_BKT && need_clr[c]) nr = 1'b0;
            nn = !reason[c] ? 1'b0 : (st.sat ? 1'b1 : need_clr[c]);
            reason[c]   = nr;
            need_clr[c] = nn;
        end
        if (row.op == OP_WRITE) begin
            mclause[row.idx] = row.clause;
            mlen[row.idx]    = row.len;
        end
    endtask

    // ----------------------------------------------------------------------
    // drive and check
    // ----------------------------------------------------------------------

    task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic drive_row(row_t row);
        wr_i         <= (row.op == OP_WRITE) ? (4'b0001 << row.idx) : 4'b0000;
        clause_i     <= row.clause;
        clause_len_i <= row.len;
        var_value_i  <= row.vars;
        apply_impl_i <= (row.op == OP_IMPL);
        apply_bkt_i  <= (row.op == OP_BKT);
        rd_en_i      <= (row.op == OP_WRITE || row.op == OP_EVAL);   // apply rows read nothing
        rd_i         <= row.idx;
    endtask

    task automatic check_outputs(string name, row_t row);
        clause_status_t                               st;
        var_vec_t                                     imp;
        var_vec_t                                     exp_var;
        logic [`SAT_NUM_VARS-1:0]                     taken;
        logic                                         exp_all_sat;
        logic                                         exp_conf;
        logic [`SAT_NUM_CLAUSES-1:0][`SAT_LEN_W-1:0]  exp_len;
        clause_vec_t                                  exp_rd;
        exp_var     = row.vars;
        taken       = '0;
        exp_all_sat = 1'b1;
        exp_conf    = 1'b0;
        for (int c = 0; c < `SAT_NUM_CLAUSES; c++) begin
            st          = clause_status_of(mclause[c], row.vars);
            imp         = implied_by(mclause[c], row.vars);
            exp_all_sat = exp_all_sat && (st.sat || st.empty);
            exp_conf    = exp_conf || st.conflict;
            exp_len[c]  = reason[c] ? '0 : mlen[c];
            for (int v = 0; v < `SAT_NUM_VARS; v++) begin
                if (!row.vars[v].assigned && !taken[v] && imp[v].assigned) begin
                    exp_var[v] = imp[v];   // lower clause index claims it first
                    taken[v]   = 1'b1;
                end
            end
        end
        exp_rd = (row.op == OP_WRITE || row.op == OP_EVAL) ? mclause[row.idx]
                                                          : clause_vec_t'(0);
        check_value(name, "var_value_o", 32'(exp_var), 32'(var_value_o));
        check_value(name, "all_sat_o", 32'(exp_all_sat), 32'(all_sat_o));
        check_value(name, "conflict_o", 32'(exp_conf), 32'(conflict_o));
        check_value(name, "clause_len_o", 32'(exp_len), 32'(clause_len_o));
        check_value(name, "clause_o", 32'(exp_rd), 32'(clause_o));
        if (row.want[2]) begin
            check_value(name, "all_sat_o (table)", 32'(row.want[1]), 32'(all_sat_o));
            check_value(name, "conflict_o (table)", 32'(row.want[0]), 32'(conflict_o));
        end
    endtask

    // ----------------------------------------------------------------------
    // test table and main sequence
    // ----------------------------------------------------------------------

    initial begin
        clause_vec_t c0;
        clause_vec_t c1;
        clause_vec_t c2;
        clause_vec_t c3;
        clause_vec_t cz;
        c0 = make_clause(8'h01, 8'h02);   // x0 | !x1
        c1 = make_clause(8'h06, 8'h00);   // x1 | x2
        c2 = make_clause(8'h18, 8'h02);   // !x1 | x3 | x4
        c3 = make_clause(8'h20, 8'h40);   // x5 | !x6
        cz = clause_vec_t'(0);

        rst          = 1'b0;
        wr_i         = '0;
        clause_i     = cz;
        clause_len_i = '0;
        rd_en_i      = 1'b0;
        rd_i         = '0;
        var_value_i  = '0;
        apply_impl_i = 1'b0;
        apply_bkt_i  = 1'b0;

        add_row("reset_state", OP_EVAL, 2'd0, cz, 4'd0, make_vars(8'h00, 8'h00), W_SAT);
        add_row("wr_c0", OP_WRITE, 2'd0, c0, 4'd2, make_vars(8'h00, 8'h00), W_SAT);
        add_row("rd_c0", OP_EVAL, 2'd0, cz, 4'd0, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("wr_c1", OP_WRITE, 2'd1, c1, 4'd2, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("rd_c1", OP_EVAL, 2'd1, cz, 4'd0, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("wr_c2", OP_WRITE, 2'd2, c2, 4'd3, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("rd_c2", OP_EVAL, 2'd2, cz, 4'd0, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("wr_c3", OP_WRITE, 2'd3, c3, 4'd2, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("rd_c3", OP_EVAL, 2'd3, cz, 4'd0, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("read_disabled", OP_BKT, 2'd3, cz, 4'd0, make_vars(8'h00, 8'h00), W_OPEN);
        add_row("all_sat", OP_EVAL, 2'd0, cz, 4'd0, make_vars(8'h2b, 8'h2b), W_SAT);
        add_row("unit_prio", OP_EVAL, 2'd1, cz, 4'd0, make_vars(8'h3d, 8'h20), W_OPEN);
        add_row("unit_c1", OP_EVAL, 2'd2, cz, 4'd0, make_vars(8'h3d, 8'h21), W_OPEN);
        add_row("conflict", OP_EVAL, 2'd3, cz, 4'd0, make_vars(8'h63, 8'h42), W_CONF);
        // c3 becomes the only unit clause once x5 is false
        add_row("impl_c3", OP_IMPL, 2'd3, cz, 4'd0, make_vars(8'h20, 8'h00), W_OPEN);
        add_row("reason_len", OP_EVAL, 2'd3, cz, 4'd0, make_vars(8'h20, 8'h00), W_OPEN);
        add_row("bkt_early", OP_BKT, 2'd3, cz, 4'd0, make_vars(8'h20, 8'h00), W_OPEN);
        add_row("c3_sat", OP_EVAL, 2'd3, cz, 4'd0, make_vars(8'h60, 8'h00), W_OPEN);
        add_row("bkt_clear", OP_BKT, 2'd3, cz, 4'd0, make_vars(8'h20, 8'h00), W_OPEN);
        add_row("len_back", OP_EVAL, 2'd3, cz, 4'd0, make_vars(8'h20, 8'h00), W_OPEN);
        add_random_rows(24);
        cycle_limit = rows.size() * 4 + 50;

        repeat (3) @(posedge clk);
        rst <= 1'b1;
        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk);
            drive_row(rows[r]);
            @(negedge clk);
            check_outputs(names[r], rows[r]);
            step_model(rows[r]);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the test did not finish within %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: design/clause_array.sv
`timescale 1ns/100ps
`include "sat_cfg.svh"

module clause_array import sat_pkg::*; (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [`SAT_NUM_CLAUSES-1:0]                    wr_i,
    input  clause_vec_t                                    clause_i,
    input  logic [`SAT_LEN_W-1:0]                          clause_len_i,
    input  logic                                           rd_en_i,
    input  logic [$clog2(`SAT_NUM_CLAUSES)-1:0]            rd_i,
    output clause_vec_t                                    clause_o,
    output logic [`SAT_NUM_CLAUSES-1:0][`SAT_LEN_W-1:0]    clause_len_o,
    input  var_vec_t                                       var_value_i,
    output var_vec_t                                       var_value_o,
    input  logic                                           apply_impl_i,
    input  logic                                           apply_bkt_i,
    output logic                                           all_sat_o,
    output logic                                           conflict_o
);

    clause_vec_t     cell_clause  [`SAT_NUM_CLAUSES];
    clause_status_t  cell_status  [`SAT_NUM_CLAUSES];
    var_vec_t        cell_implied [`SAT_NUM_CLAUSES];

    for (genvar c = 0; c < `SAT_NUM_CLAUSES; c++) begin : g_cell
        clause_cell u_cell (
            .clk          (clk),
            .rst          (rst),
            .wr_i         (wr_i[c]),
            .clause_i     (clause_i),
            .clause_len_i (clause_len_i),
            .var_i        (var_value_i),
            .apply_impl_i (apply_impl_i),
            .apply_bkt_i  (apply_bkt_i),
            .clause_o     (cell_clause[c]),
            .clause_len_o (clause_len_o[c]),
            .status_o     (cell_status[c]),
            .implied_o    (cell_implied[c])
        );
    end

    assign clause_o = rd_en_i ? cell_clause[rd_i] : clause_vec_t'(0);

    // ---------------------------------------------------------------------
    // implication merge, lowest clause index wins
    // ---------------------------------------------------------------------

    always_comb begin
        logic found;
        var_value_o = var_value_i;
        for (int v = 0; v < `SAT_NUM_VARS; v++) begin
            found = 1'b0;
            if (!var_value_i[v].assigned) begin
                for (int c = 0; c < `SAT_NUM_CLAUSES; c++) begin
                    if (!found && cell_implied[c][v].assigned) begin
                        var_value_o[v] = cell_implied[c][v];
                        found          = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        all_sat_o  = 1'b1;
        conflict_o = 1'b0;
        for (int c = 0; c < `SAT_NUM_CLAUSES; c++) begin
            all_sat_o  = all_sat_o && (cell_status[c].sat || cell_status[c].empty);
            conflict_o = conflict_o || cell_status[c].conflict;
        end
    end

endmodule

// File: design/clause_cell.sv
`timescale 1ns/100ps
`include "sat_cfg.svh"

module clause_cell import sat_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_i,
    input  clause_vec_t            clause_i,
    input  logic [`SAT_LEN_W-1:0]  clause_len_i,
    input  var_vec_t               var_i,
    input  logic                   apply_impl_i,
    input  logic                   apply_bkt_i,
    output clause_vec_t            clause_o,
    output logic [`SAT_LEN_W-1:0]  clause_len_o,
    output clause_status_t         status_o,
    output var_vec_t               implied_o
);

    clause_vec_t               clause_q;
    logic [`SAT_LEN_W-1:0]     len_q;
    logic                      reason_q;
    logic                      need_clear_q;
    logic [`SAT_NUM_VARS-1:0]  true_mask;
    logic [`SAT_NUM_VARS-1:0]  free_mask;
    free_cnt_t                 free_cnt;

    // ---------------------------------------------------------------------
    // clause storage
    // ---------------------------------------------------------------------

    // an unloaded cell holds an empty clause
    always_ff @(posedge clk) begin
        if (!rst) begin
            clause_q <= clause_vec_t'(0);
            len_q    <= '0;
        end else if (wr_i) begin
            clause_q <= clause_i;
            len_q    <= clause_len_i;
        end
    end

    // ---------------------------------------------------------------------
    // evaluation
    // ---------------------------------------------------------------------

    lit_decode u_decode (
        .clause_i    (clause_q),
        .var_i       (var_i),
        .true_mask_o (true_mask),
        .free_mask_o (free_mask),
        .free_cnt_o  (free_cnt)
    );

    clause_eval u_eval (
        .clause_i    (clause_q),
        .true_mask_i (true_mask),
        .free_mask_i (free_mask),
        .free_cnt_i  (free_cnt),
        .status_o    (status_o),
        .implied_o   (implied_o)
    );

    // ---------------------------------------------------------------------
    // reason tracking
    // ---------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst) begin
            reason_q <= 1'b0;
        end else if (apply_impl_i && status_o.unit) begin
            reason_q <= 1'b1;
        end else if (apply_bkt_i && need_clear_q) begin
            reason_q <= 1'b0;   // the implied variable was undone
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || !reason_q) begin
            need_clear_q <= 1'b0;
        end else if (status_o.sat) begin
            need_clear_q <= 1'b1;
        end
    end

    assign clause_o     = clause_q;
    assign clause_len_o = reason_q ? '0 : len_q;   // a reason clause hides its length

endmodule

// File: design/clause_eval.sv
`timescale 1ns/100ps
`include "sat_cfg.svh"

module clause_eval import sat_pkg::*; (
    input  clause_vec_t               clause_i,
    input  logic [`SAT_NUM_VARS-1:0]  true_mask_i,
    input  logic [`SAT_NUM_VARS-1:0]  free_mask_i,
    input  free_cnt_t                 free_cnt_i,
    output clause_status_t            status_o,
    output var_vec_t                  implied_o
);

    logic                            lit_none_all;
    logic [$clog2(`SAT_NUM_VARS)-1:0] unit_idx;
    logic                            unit_pos;

    // ---------------------------------------------------------------------
    // clause status
    // ---------------------------------------------------------------------

    always_comb begin
        lit_none_all = 1'b1;
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            if (clause_i[i] == LIT_POS || clause_i[i] == LIT_NEG) begin
                lit_none_all = 1'b0;
            end
        end
    end

    always_comb begin
        status_o.sat      = |true_mask_i;
        status_o.empty    = lit_none_all;
        // every literal false, an empty clause is never a conflict
        status_o.conflict = !status_o.sat && !lit_none_all && (free_cnt_i == 2'd0);
        status_o.unit     = !status_o.sat && (free_cnt_i == 2'd1);
    end

    // ---------------------------------------------------------------------
    // implication of a unit clause
    // ---------------------------------------------------------------------

    // with exactly one free literal the first set bit is the only one
    always_comb begin
        unit_idx = '0;
        for (int i = `SAT_NUM_VARS - 1; i >= 0; i--) begin
            if (free_mask_i[i]) begin
                unit_idx = i[$clog2(`SAT_NUM_VARS)-1:0];
            end
        end
    end

    assign unit_pos = (clause_i[unit_idx] == LIT_POS);

    always_comb begin
        implied_o = '0;
        if (status_o.unit) begin
            implied_o[unit_idx].implied  = 1'b1;
            implied_o[unit_idx].assigned = 1'b1;
            implied_o[unit_idx].value    = unit_pos;   // LIT_NEG implies zero
        end
    end

endmodule

// File: design/lit_decode.sv
`timescale 1ns/100ps
`include "sat_cfg.svh"

module lit_decode import sat_pkg::*; (
    input  clause_vec_t               clause_i,
    input  var_vec_t                  var_i,
    output logic [`SAT_NUM_VARS-1:0]  true_mask_o,
    output logic [`SAT_NUM_VARS-1:0]  free_mask_o,
    output free_cnt_t                 free_cnt_o
);

    logic [`SAT_NUM_VARS-1:0] pos_lit;
    logic [`SAT_NUM_VARS-1:0] neg_lit;

    // ---------------------------------------------------------------------
    // per literal decode
    // ---------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            pos_lit[i] = (clause_i[i] == LIT_POS);
            neg_lit[i] = (clause_i[i] == LIT_NEG);
        end
    end

    always_comb begin
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            // a literal only counts when the slot holds a polarity
            if (var_i[i].assigned) begin
                true_mask_o[i] = (pos_lit[i] &&  var_i[i].value) ||
                                 (neg_lit[i] && !var_i[i].value);
                free_mask_o[i] = 1'b0;
            end else begin
                true_mask_o[i] = 1'b0;
                free_mask_o[i] = pos_lit[i] || neg_lit[i];
            end
        end
    end

    // ---------------------------------------------------------------------
    // free literal count
    // ---------------------------------------------------------------------

    always_comb begin
        free_cnt_o = 2'd0;
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            if (free_mask_o[i] && free_cnt_o != 2'd2) begin
                free_cnt_o = free_cnt_o + 2'd1;   // stop at two
            end
        end
    end

endmodule

// File: design/sat_pkg.sv
`include "sat_cfg.svh"

package sat_pkg;

    // ---------------------------------------------------------------------
    // variable assignment state
    // ---------------------------------------------------------------------

    typedef struct packed {
        logic implied;   // value came from a clause and not from a decision
        logic assigned;
        logic value;
    } var_state_t;

    typedef var_state_t [`SAT_NUM_VARS-1:0] var_vec_t;

    // ---------------------------------------------------------------------
    // clause storage and status
    // ---------------------------------------------------------------------

    // two bits per variable, 11 is never written and reads as no literal
    typedef enum logic [1:0] {
        LIT_NONE = 2'b00,
        LIT_POS  = 2'b01,
        LIT_NEG  = 2'b10
    } lit_code_t;

    typedef lit_code_t [`SAT_NUM_VARS-1:0] clause_vec_t;

    typedef struct packed {
        logic sat;
        logic conflict;
        logic unit;
        logic empty;
    } clause_status_t;

    // saturates at 2, evaluation only needs to tell none, one and many
    typedef logic [1:0] free_cnt_t;

endpackage

// File: design/sat_cfg.svh
`ifndef SAT_CFG_SVH
`define SAT_CFG_SVH

// ---------------------------------------------------------------------
// clause array sizing
// ---------------------------------------------------------------------

// variables visible to every clause, each literal slot maps to one
`define SAT_NUM_VARS    8

// clause cells in the array, one write strobe bit each
`define SAT_NUM_CLAUSES 4

// width of a stored clause length
`define SAT_LEN_W       4

`endif
